/* Makefile */
SIM      = verilator
TOP      = tb_line_swap
RTL_TOP  = line_swap_buffer
FILELIST = project.f
FLAGS    = --binary --timing
LINTFLAGS = --lint-only -Wall --timing
BUILD    = obj_dir
LOG      = sim.log

.PHONY: all build run lint clean

all: run

build:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)

run: build
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -q "TEST RESULT: PASS" $(LOG)

lint:
	$(SIM) $(LINTFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD) $(LOG)

/* cam_ingress.sv */
`timescale 1ns/10ps

module cam_ingress #(
    parameter int H_ACT = 1280,
    parameter int DEPTH = 2560
) (
    input  logic                 clk,
    input  logic                 rstn,
    input  video_pkg::cam_pack_t pack,
    input  logic                 flush,
    input  logic                 pop,
    output video_pkg::byte_t     rd_byte,
    output logic                 line_ready,
    output logic                 vsync,
    output logic                 overflow
);

    video_pkg::rgb565_t pix565;

    // keep the top bits of each channel
    function automatic video_pkg::rgb565_t to_rgb565(
        input video_pkg::chan_t r,
        input video_pkg::chan_t g,
        input video_pkg::chan_t b
    );
        return {r[7:3], g[7:2], b[7:3]};
    endfunction

    assign pix565 = to_rgb565(pack.r, pack.g, pack.b);
    assign vsync  = pack.vsync;   // frame timing goes to the controller

    line_fifo #(
        .H_ACT(H_ACT),
        .DEPTH(DEPTH)
    ) u_fifo (
        .clk       (clk),
        .rstn      (rstn),
        .flush     (flush),
        .wr_en     (pack.de),
        .wr_data   (pix565),
        .pop       (pop),
        .rd_byte   (rd_byte),
        .line_ready(line_ready),
        .overflow  (overflow)
    );

endmodule

/* error_stretch.sv */
`timescale 1ns/10ps

module error_stretch #(
    parameter int STRETCH = 37_500_000
) (
    input  logic clk,
    input  logic rstn,
    input  logic trigger,
    output logic hold
);

    localparam int CW = $clog2(STRETCH + 1);

    logic [CW-1:0] cnt;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            cnt <= '0;
        end else if (trigger) begin
            cnt <= CW'(STRETCH);   // restart on every new pulse
        end else if (cnt != '0) begin
            cnt <= cnt - 1'b1;
        end
    end

    assign hold = (cnt != '0);

endmodule

/* line_fifo.sv */
`timescale 1ns/10ps

module line_fifo #(
    parameter int H_ACT = 1280,
    parameter int DEPTH = 2560
) (
    input  logic               clk,
    input  logic               rstn,
    input  logic               flush,
    input  logic               wr_en,
    input  video_pkg::rgb565_t wr_data,
    input  logic               pop,
    output video_pkg::byte_t   rd_byte,
    output logic               line_ready,
    output logic               overflow
);

    localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CW = $clog2(DEPTH + 1);

    video_pkg::rgb565_t mem [DEPTH];

    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [CW-1:0] count;       // pixels held
    logic          lo_sel;      // head pixel already gave its high byte
    logic          full;
    logic          wr_ok;
    logic          pix_done;

    function automatic logic [AW-1:0] wrap_inc(input logic [AW-1:0] p);
        return (p == AW'(DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    assign full     = (count == CW'(DEPTH));
    assign wr_ok    = wr_en && !full && !flush;
    assign pix_done = pop && lo_sel && (count != '0);

    assign rd_byte    = lo_sel ? mem[rd_ptr][7:0] : mem[rd_ptr][15:8];
    assign line_ready = (count >= CW'(H_ACT));

    always_ff @(posedge clk) begin
        if (wr_ok) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            lo_sel   <= 1'b0;
            overflow <= 1'b0;
        end else if (flush) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            lo_sel   <= 1'b0;
            overflow <= 1'b0;
        end else begin
            if (wr_ok) wr_ptr <= wrap_inc(wr_ptr);
            if (pix_done) rd_ptr <= wrap_inc(rd_ptr);
            if (pop && count != '0) lo_sel <= ~lo_sel;   // high byte, then low
            count    <= count + CW'(wr_ok) - CW'(pix_done);
            overflow <= wr_en && full;                   // dropped pixel
        end
    end

endmodule

/* line_swap_buffer.sv */
`timescale 1ns/10ps

module line_swap_buffer #(
    parameter int H_ACT   = 1280,
    parameter int V_ACT   = 720,
    parameter int DEPTH   = 2 * H_ACT,
    parameter int STRETCH = 37_500_000
) (
    input  logic                 clk,
    input  logic                 rstn,
    input  video_pkg::cam_pack_t cam1,
    input  video_pkg::cam_pack_t cam2,
    input  logic                 trig,
    input  logic                 read_en,
    output swap_pkg::status_t    status,
    output video_pkg::byte_t     cam_data,
    output logic                 cam_valid,
    output logic                 error
);

    logic             flush;
    logic             cam1_pop;
    logic             cam2_pop;
    logic             cam1_ready;
    logic             cam2_ready;
    logic             cam1_vsync;
    logic             cam2_vsync;
    logic             cam1_ovf;
    logic             cam2_ovf;
    logic             sync_err;
    video_pkg::byte_t cam1_byte;
    video_pkg::byte_t cam2_byte;
    logic [2:0]       err_pulse;
    logic [2:0]       err_hold;

    cam_ingress #(
        .H_ACT(H_ACT),
        .DEPTH(DEPTH)
    ) u_cam1 (
        .clk       (clk),
        .rstn      (rstn),
        .pack      (cam1),
        .flush     (flush),
        .pop       (cam1_pop),
        .rd_byte   (cam1_byte),
        .line_ready(cam1_ready),
        .vsync     (cam1_vsync),
        .overflow  (cam1_ovf)
    );

    cam_ingress #(
        .H_ACT(H_ACT),
        .DEPTH(DEPTH)
    ) u_cam2 (
        .clk       (clk),
        .rstn      (rstn),
        .pack      (cam2),
        .flush     (flush),
        .pop       (cam2_pop),
        .rd_byte   (cam2_byte),
        .line_ready(cam2_ready),
        .vsync     (cam2_vsync),
        .overflow  (cam2_ovf)
    );

    line_swap_ctrl #(
        .H_ACT(H_ACT),
        .V_ACT(V_ACT)
    ) u_ctrl (
        .clk       (clk),
        .rstn      (rstn),
        .trig      (trig),
        .read_en   (read_en),
        .cam1_vsync(cam1_vsync),
        .cam2_vsync(cam2_vsync),
        .cam1_ready(cam1_ready),
        .cam2_ready(cam2_ready),
        .cam1_byte (cam1_byte),
        .cam2_byte (cam2_byte),
        .flush     (flush),
        .cam1_pop  (cam1_pop),
        .cam2_pop  (cam2_pop),
        .status    (status),
        .cam_data  (cam_data),
        .cam_valid (cam_valid),
        .sync_err  (sync_err)
    );

    // overflow cam1, overflow cam2, vsync mismatch
    assign err_pulse = {sync_err, cam2_ovf, cam1_ovf};

    for (genvar i = 0; i < 3; i++) begin : g_err
        error_stretch #(
            .STRETCH(STRETCH)
        ) u_stretch (
            .clk    (clk),
            .rstn   (rstn),
            .trigger(err_pulse[i]),
            .hold   (err_hold[i])
        );
    end

    assign error = |err_hold;

endmodule

/* line_swap_ctrl.sv */
`timescale 1ns/10ps

module line_swap_ctrl #(
    parameter int H_ACT = 1280,
    parameter int V_ACT = 720
) (
    input  logic              clk,
    input  logic              rstn,
    input  logic              trig,
    input  logic              read_en,
    input  logic              cam1_vsync,
    input  logic              cam2_vsync,
    input  logic              cam1_ready,
    input  logic              cam2_ready,
    input  video_pkg::byte_t  cam1_byte,
    input  video_pkg::byte_t  cam2_byte,
    output logic              flush,
    output logic              cam1_pop,
    output logic              cam2_pop,
    output swap_pkg::status_t status,
    output video_pkg::byte_t  cam_data,
    output logic              cam_valid,
    output logic              sync_err
);

    swap_pkg::swap_state_t state;
    swap_pkg::bcnt_t       byte_cnt;
    swap_pkg::row_t        row_cnt;     // row being fetched
    swap_pkg::row_t        row_q;       // row shown on status
    logic                  acquire_q;
    logic                  cam_id_q;
    logic                  vs1_d;
    logic                  vs2_d;
    logic                  fall1;
    logic                  fall2;
    logic                  pop_any;
    logic                  last_byte;

    assign fall1 = vs1_d && !cam1_vsync;
    assign fall2 = vs2_d && !cam2_vsync;

    // fifos stay empty until a frame start is seen
    assign flush = (state == swap_pkg::IDLE) || (state == swap_pkg::WAIT_VSYNC);

    assign cam1_pop  = read_en && (state == swap_pkg::READ_CAM1);
    assign cam2_pop  = read_en && (state == swap_pkg::READ_CAM2);
    assign pop_any   = cam1_pop || cam2_pop;
    assign last_byte = pop_any && (byte_cnt == swap_pkg::bcnt_t'(2 * H_ACT - 1));

    assign status = '{acquire: acquire_q, cam_id: cam_id_q, cam_row: row_q};

    always_ff @(posedge clk) begin
        if (pop_any) begin
            cam_data <= cam2_pop ? cam2_byte : cam1_byte;
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state     <= swap_pkg::IDLE;
            byte_cnt  <= '0;
            row_cnt   <= '0;
            row_q     <= '0;
            acquire_q <= 1'b0;
            cam_id_q  <= 1'b0;
            vs1_d     <= 1'b0;
            vs2_d     <= 1'b0;
            sync_err  <= 1'b0;
            cam_valid <= 1'b0;
        end else begin
            vs1_d     <= cam1_vsync;
            vs2_d     <= cam2_vsync;
            acquire_q <= 1'b0;
            sync_err  <= 1'b0;
            cam_valid <= pop_any;   // one cycle behind the pop
            if (pop_any) byte_cnt <= last_byte ? '0 : byte_cnt + 1'b1;

            case (state)
                swap_pkg::IDLE: begin
                    cam_id_q <= 1'b0;
                    row_cnt  <= '0;
                    row_q    <= '0;
                    byte_cnt <= '0;
                    if (trig) state <= swap_pkg::WAIT_VSYNC;
                end
                swap_pkg::WAIT_VSYNC: begin
                    if (fall1 && fall2) begin
                        state <= swap_pkg::WAIT_CAM1;
                    end else if (fall1 || fall2) begin
                        sync_err <= 1'b1;   // cameras out of step
                        state    <= swap_pkg::IDLE;
                    end
                end
                swap_pkg::WAIT_CAM1: begin
                    if (cam1_ready) begin
                        acquire_q <= 1'b1;
                        cam_id_q  <= 1'b0;
                        row_q     <= row_cnt;
                        state     <= swap_pkg::READ_CAM1;
                    end
                end
                swap_pkg::READ_CAM1: begin
                    if (last_byte) state <= swap_pkg::WAIT_CAM2;
                end
                swap_pkg::WAIT_CAM2: begin
                    if (cam2_ready) begin
                        acquire_q <= 1'b1;
                        cam_id_q  <= 1'b1;
                        state     <= swap_pkg::READ_CAM2;
                    end
                end
                swap_pkg::READ_CAM2: begin
                    if (last_byte) begin
                        if (row_cnt == swap_pkg::row_t'(V_ACT - 1)) begin
                            state <= swap_pkg::IDLE;   // frame done
                        end else begin
                            row_cnt <= row_cnt + 1'b1;
                            state   <= swap_pkg::WAIT_CAM1;
                        end
                    end
                end
                default: state <= swap_pkg::IDLE;
            endcase
        end
    end

endmodule

/* project.f */
video_pkg.sv
swap_pkg.sv
line_fifo.sv
cam_ingress.sv
error_stretch.sv
line_swap_ctrl.sv
line_swap_buffer.sv
tb_clock.sv
tb_line_swap.sv

/* swap_pkg.sv */
package swap_pkg;

    typedef enum logic [2:0] {
        IDLE       = 3'd0,
        WAIT_VSYNC = 3'd1,
        WAIT_CAM1  = 3'd2,
        READ_CAM1  = 3'd3,
        WAIT_CAM2  = 3'd4,
        READ_CAM2  = 3'd5
    } swap_state_t;

    typedef logic [9:0]  row_t;
    typedef logic [11:0] bcnt_t;   // bytes within one line, up to 2 x 2048

    typedef struct packed {
        logic acquire;
        logic cam_id;      // 0 = camera 1, 1 = camera 2
        row_t cam_row;
    } status_t;

endpackage

/* tb_clock.sv */
`timescale 1ns/10ps

module tb_clock #(
    parameter int RST_CYCLES = 16
) (
    output logic clk,
    output logic rstn
);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;   // 100 ns period
    end

    initial begin
        rstn = 1'b0;
        repeat (RST_CYCLES) @(posedge clk);
        rstn <= 1'b1;
    end

endmodule

/* tb_line_swap.sv */
`timescale 1ns/10ps

module tb_line_swap;

    localparam int H_ACT   = 8;
    localparam int V_ACT   = 4;
    localparam int DEPTH   = 2 * H_ACT;
    localparam int STRETCH = 20;
    localparam logic [31:0] SEED = 32'h58f80bfd;

    logic                 clk;
    logic                 rstn;
    video_pkg::cam_pack_t cam1;
    video_pkg::cam_pack_t cam2;
    logic                 trig;
    logic                 read_en;
    swap_pkg::status_t    status;
    video_pkg::byte_t     cam_data;
    logic                 cam_valid;
    logic                 error;

    video_pkg::byte_t exp_q[$];   // expected output bytes, in order
    video_pkg::byte_t exp_b;
    int               frame_idx;   // bytes checked in the current frame
    int               acq_cnt;
    int               rd_mode;     // 0 high, 1 random, 2 low
    logic             no_acq;
    logic             rd_prev;     // read_en seen at the previous negedge
    int               mism_cnt;
    int               fail_cnt;
    int               tmo_cnt;

    tb_clock u_clk (
        .clk (clk),
        .rstn(rstn)
    );

    line_swap_buffer #(
        .H_ACT  (H_ACT),
        .V_ACT  (V_ACT),
        .STRETCH(STRETCH)
    ) DUT (
        .clk      (clk),
        .rstn     (rstn),
        .cam1     (cam1),
        .cam2     (cam2),
        .trig     (trig),
        .read_en  (read_en),
        .status   (status),
        .cam_data (cam_data),
        .cam_valid(cam_valid),
        .error    (error)
    );

    // rgb888 to rgb565 by integer division of each channel
    function automatic logic [15:0] ref_rgb565(input logic [23:0] rgb);
        int r5;
        int g6;
        int b5;
        r5 = int'(rgb[23:16]) / 8;
        g6 = int'(rgb[15:8]) / 4;
        b5 = int'(rgb[7:0]) / 8;
        return 16'(r5 * 2048 + g6 * 32 + b5);
    endfunction

    function automatic video_pkg::cam_pack_t pix_word(input logic [23:0] rgb);
        video_pkg::cam_pack_t p;
        p    = '0;
        p.de = 1'b1;
        p.r  = rgb[23:16];
        p.g  = rgb[15:8];
        p.b  = rgb[7:0];
        return p;
    endfunction

    task automatic finish_run();
        $display("errors: mismatches %0d, other failures %0d, timeouts %0d",
                 mism_cnt, fail_cnt, tmo_cnt);
        if (mism_cnt == 0 && fail_cnt == 0 && tmo_cnt == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    endtask

    task automatic timed_out(input string what);
        tmo_cnt++;
        $display("Timeout: %s", what);
        finish_run();
    endtask

    task automatic drive(input video_pkg::cam_pack_t p1, input video_pkg::cam_pack_t p2);
        @(posedge clk);
        cam1 <= p1;
        cam2 <= p2;
    endtask

    task automatic idle_cycles(input int n);
        for (int i = 0; i < n; i++) drive('0, '0);
    endtask

    task automatic pulse_trig();
        @(posedge clk);
        trig <= 1'b1;
        @(posedge clk);
        trig <= 1'b0;
    endtask

    // three cycles high, then the falling edge
    task automatic vsync_pulse(input logic v1, input logic v2);
        video_pkg::cam_pack_t p1;
        video_pkg::cam_pack_t p2;
        p1       = '0;
        p2       = '0;
        p1.vsync = v1;
        p2.vsync = v2;
        for (int i = 0; i < 3; i++) drive(p1, p2);
        drive('0, '0);
    endtask

    task automatic wait_reset(input int limit);
        int i;
        i = 0;
        while (rstn !== 1'b1 && i < limit) begin
            i++;
            @(posedge clk);
        end
        if (rstn !== 1'b1) timed_out("reset was never released");
    endtask

    task automatic wait_drained(input int limit);
        int i;
        i = 0;
        @(negedge clk);
        while (exp_q.size() != 0 && i < limit) begin
            i++;
            @(negedge clk);
        end
        if (exp_q.size() != 0) timed_out("expected bytes never all arrived");
    endtask

    task automatic check_error_hold();
        int i;
        int n;
        i = 0;
        n = 0;
        @(negedge clk);
        while (error !== 1'b1 && i < 50) begin
            i++;
            @(negedge clk);
        end
        if (error !== 1'b1) begin
            timed_out("error did not rise");
        end else begin
            while (error === 1'b1 && n <= STRETCH + 10) begin
                n++;
                @(negedge clk);
            end
            if (error !== 1'b0) begin
                timed_out("error did not fall");
            end else if (n < STRETCH) begin
                fail_cnt++;
                $display("error held for %0d cycles, at least %0d expected", n, STRETCH);
            end
        end
    endtask

    // one triggered frame on both cameras, lines separated by gap idle cycles
    task automatic run_frame(input int gap);
        logic [23:0] q1[$];
        logic [23:0] q2[$];
        logic [15:0] w;
        for (int i = 0; i < V_ACT * H_ACT; i++) begin
            q1.push_back(24'($urandom));
            q2.push_back(24'($urandom));
        end
        frame_idx = 0;
        acq_cnt   = 0;
        for (int r = 0; r < V_ACT; r++) begin
            for (int c = 0; c < H_ACT; c++) begin
                w = ref_rgb565(q1[r * H_ACT + c]);
                exp_q.push_back(w[15:8]);
                exp_q.push_back(w[7:0]);
            end
            for (int c = 0; c < H_ACT; c++) begin
                w = ref_rgb565(q2[r * H_ACT + c]);
                exp_q.push_back(w[15:8]);
                exp_q.push_back(w[7:0]);
            end
        end
        pulse_trig();
        vsync_pulse(1'b1, 1'b1);
        idle_cycles(4);
        for (int r = 0; r < V_ACT; r++) begin
            for (int c = 0; c < H_ACT; c++) begin
                drive(pix_word(q1[r * H_ACT + c]), pix_word(q2[r * H_ACT + c]));
            end
            idle_cycles(gap);
        end
        wait_drained(4000);
        idle_cycles(4);
        @(negedge clk);
        if (acq_cnt != 2 * V_ACT) begin
            fail_cnt++;
            $display("acquire pulsed %0d times in the frame, %0d expected",
                     acq_cnt, 2 * V_ACT);
        end
        if (error !== 1'b0) begin
            fail_cnt++;
            $display("error raised during a clean frame");
        end
    endtask

    always @(posedge clk) begin
        if (rd_mode == 1) read_en <= 1'($urandom_range(0, 1));
        else read_en <= (rd_mode == 0);
    end

    // output checker, sampled away from the active edge
    always @(negedge clk) begin
        if (!rstn) begin
            if (status.acquire !== 1'b0 || cam_valid !== 1'b0 || error !== 1'b0) begin
                fail_cnt++;
                $display("acquire, cam_valid or error not low during reset");
            end
            if (status.cam_row !== '0) begin
                mism_cnt++;
                $display("Mismatch status.cam_row: got 0x%h, expected 0x%h", status.cam_row, 10'h0);
            end
        end else begin
            if (status.acquire === 1'b1) begin
                if (no_acq) begin
                    fail_cnt++;
                    $display("acquire pulsed while no line was due");
                end else begin
                    if (status.cam_id !== 1'(acq_cnt % 2)) begin
                        mism_cnt++;
                        $display("Mismatch status.cam_id: got 0x%h, expected 0x%h",
                                 status.cam_id, 1'(acq_cnt % 2));
                    end
                    if (status.cam_row !== swap_pkg::row_t'(acq_cnt / 2)) begin
                        mism_cnt++;
                        $display("Mismatch status.cam_row: got 0x%h, expected 0x%h",
                                 status.cam_row, swap_pkg::row_t'(acq_cnt / 2));
                    end
                    acq_cnt++;
                end
            end
            if (cam_valid === 1'b1) begin
                if (rd_prev !== 1'b1) begin
                    fail_cnt++;
                    $display("cam_valid high although read_en was low the cycle before");
                end
                if (exp_q.size() == 0) begin
                    fail_cnt++;
                    $display("byte 0x%h on cam_data while none was expected", cam_data);
                end else begin
                    exp_b = exp_q.pop_front();
                    if (cam_data !== exp_b) begin
                        mism_cnt++;
                        $display("Mismatch cam_data: got 0x%h, expected 0x%h", cam_data, exp_b);
                    end
                    if (status.cam_row !== swap_pkg::row_t'(frame_idx / (4 * H_ACT))) begin
                        mism_cnt++;
                        $display("Mismatch status.cam_row: got 0x%h, expected 0x%h",
                                 status.cam_row, swap_pkg::row_t'(frame_idx / (4 * H_ACT)));
                    end
                    if (status.cam_id !== 1'((frame_idx / (2 * H_ACT)) % 2)) begin
                        mism_cnt++;
                        $display("Mismatch status.cam_id: got 0x%h, expected 0x%h",
                                 status.cam_id, 1'((frame_idx / (2 * H_ACT)) % 2));
                    end
                    frame_idx++;
                end
            end
        end
        rd_prev = read_en;   // pop decision for the next edge
    end

    initial begin
        void'($urandom(SEED));
        cam1      = '0;
        cam2      = '0;
        trig      = 1'b0;
        read_en   = 1'b0;
        rd_mode   = 0;
        no_acq    = 1'b0;
        rd_prev   = 1'b0;
        frame_idx = 0;
        acq_cnt   = 0;
        mism_cnt  = 0;
        fail_cnt  = 0;
        tmo_cnt   = 0;
        wait_reset(40);
        idle_cycles(4);
        @(negedge clk);
        if (status.acquire !== 1'b0 || cam_valid !== 1'b0 || error !== 1'b0) begin
            fail_cnt++;
            $display("acquire, cam_valid or error not low after reset");
        end
        if (status.cam_row !== '0) begin
            mism_cnt++;
            $display("Mismatch status.cam_row: got 0x%h, expected 0x%h", status.cam_row, 10'h0);
        end

        run_frame(32);      // read_en held high
        rd_mode = 1;
        run_frame(120);     // room for random stalls

        // vsync on camera 1 only
        rd_mode = 0;
        no_acq  = 1'b1;
        pulse_trig();
        vsync_pulse(1'b1, 1'b0);
        check_error_hold();
        no_acq  = 1'b0;
        run_frame(32);

        // camera 2 overruns its fifo with nothing read
        rd_mode = 2;
        no_acq  = 1'b1;
        pulse_trig();
        vsync_pulse(1'b1, 1'b1);
        for (int i = 0; i < DEPTH + 4; i++) drive('0, pix_word(24'($urandom)));
        idle_cycles(1);
        check_error_hold();
        finish_run();
    end

endmodule

/* video_pkg.sv */
package video_pkg;

    localparam int CHAN_W = 8;     // one colour channel
    localparam int PIX_W  = 16;    // rgb565 pixel
    localparam int BYTE_W = 8;

    typedef logic [CHAN_W-1:0] chan_t;
    typedef logic [PIX_W-1:0]  rgb565_t;
    typedef logic [BYTE_W-1:0] byte_t;

    // one camera word, msb first
    typedef struct packed {
        logic  vsync;
        logic  hsync;
        logic  de;
        chan_t r;
        chan_t g;
        chan_t b;
    } cam_pack_t;

endpackage
